// ==== logic/seg_pkg.sv ====
package seg_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Display geometry.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int DIGITS   = 8;
    localparam int NIBBLE_W = 4;

    typedef logic [NIBBLE_W*DIGITS-1:0] disp_value_t;  // Eight hex digits.
    typedef logic [NIBBLE_W-1:0]        nibble_t;
    typedef logic [$clog2(DIGITS)-1:0]  digit_idx_t;   // 0 is the rightmost digit.

    // Active low. Bits 0..6 are segments a..g, bit 7 the decimal point.
    typedef logic [7:0] seg_t;

    typedef logic [DIGITS-1:0] anode_t;  // Active low, one per digit.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host write channel.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic        valid;
        disp_value_t value;
    } disp_wr_t;

    // Commit control in the frame buffer.
    typedef enum logic {
        S_IDLE,     // Nothing queued.
        S_PENDING   // Head entry waits for the frame end.
    } scan_state_t;

endpackage

// ==== logic/scan_tick_gen.sv ====
`timescale 1ns/1ns

module scan_tick_gen #(
    parameter int TICK_DIV = 100000
) (
    input  logic clock,
    input  logic rst,
    output logic tick
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CNT_W-1:0] cnt;
    logic             wrap;

    assign wrap = (cnt == CNT_W'(TICK_DIV - 1));

    always_ff @(posedge clock) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            cnt  <= wrap ? '0 : cnt + CNT_W'(1);
            tick <= wrap;  // One cycle per wrap.
        end
    end

    // A divider above one never produces back-to-back ticks.
    if (TICK_DIV > 1) begin : g_tick_chk
        a_tick_single: assert property (
            @(posedge clock) disable iff (rst) tick |=> !tick
        );
    end

endmodule

// ==== logic/hex_glyph_rom.sv ====
`timescale 1ns/1ns

module hex_glyph_rom
    import seg_pkg::*;
(
    input  nibble_t nibble,
    output seg_t    glyph
);

    // Active-low cathodes, decimal point kept dark in every entry.
    always_comb begin
        case (nibble)
            4'h0:    glyph = 8'hC0;
            4'h1:    glyph = 8'hF9;
            4'h2:    glyph = 8'hA4;
            4'h3:    glyph = 8'hB0;
            4'h4:    glyph = 8'h99;
            4'h5:    glyph = 8'h92;
            4'h6:    glyph = 8'h82;
            4'h7:    glyph = 8'hF8;
            4'h8:    glyph = 8'h80;
            4'h9:    glyph = 8'h90;
            4'hA:    glyph = 8'h88;
            4'hB:    glyph = 8'h83;  // Lower case b.
            4'hC:    glyph = 8'hC6;
            4'hD:    glyph = 8'hA1;  // Lower case d.
            4'hE:    glyph = 8'h86;
            4'hF:    glyph = 8'h8E;
            default: glyph = 8'hFF;
        endcase
    end

endmodule

// ==== logic/digit_scanner.sv ====
`timescale 1ns/1ns

module digit_scanner
    import seg_pkg::*;
(
    input  logic        clock,
    input  logic        rst,
    input  logic        tick,
    input  disp_value_t shown,
    input  seg_t        glyph,
    output nibble_t     nibble,
    output logic        frame_end,
    output seg_t        ca,
    output anode_t      an
);

    localparam digit_idx_t LAST_DIGIT = digit_idx_t'(DIGITS - 1);

    digit_idx_t idx;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Digit index.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Wrap step, the frame buffer commits on this edge.
    assign frame_end = tick && (idx == LAST_DIGIT);

    always_ff @(posedge clock) begin
        if (rst) begin
            idx <= '0;
        end else if (tick) begin
            idx <= idx + digit_idx_t'(1);  // Wraps 7 to 0.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output stage.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Nibble of the current digit, sent to the glyph table.
    assign nibble = shown[{idx, 2'b00} +: NIBBLE_W];

    // Pins are registered from the index and the display register together,
    // so a value committed at the wrap is already in place for digit 0.
    always_ff @(posedge clock) begin
        if (rst) begin
            an <= ~anode_t'(1);
        end else begin
            an <= ~(anode_t'(1) << idx);
        end
    end

    always_ff @(posedge clock) begin
        ca <= glyph;  // Follows the selected nibble.
    end

    // Exactly one digit is driven at any time.
    a_one_anode: assert property (
        @(posedge clock) disable iff (rst) $onehot(~an)
    );

endmodule

// ==== logic/frame_buffer.sv ====
`timescale 1ns/1ns

module frame_buffer
    import seg_pkg::*;
#(
    parameter int DEPTH = 2
) (
    input  logic        clock,
    input  logic        rst,
    input  disp_wr_t    wr,
    input  logic        frame_end,
    output disp_value_t shown,
    output logic        credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    disp_value_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    scan_state_t      state;
    scan_state_t      state_next;
    logic             push;
    logic             pop;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Queue control.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign push   = wr.valid;  // Host only writes while holding a credit.
    assign pop    = frame_end && (state == S_PENDING);
    assign credit = pop;       // One credit back per commit.

    // Entry waiting after this cycle.
    always_comb begin
        if (push) begin
            state_next = S_PENDING;
        end else if (pop && count == CNT_W'(1)) begin
            state_next = S_IDLE;  // Last entry leaves.
        end else begin
            state_next = state;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            state  <= S_IDLE;
        end else begin
            state <= state_next;
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            if (push && !pop) begin
                count <= count + CNT_W'(1);
            end else if (pop && !push) begin
                count <= count - CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= wr.value;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Display register.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock) begin
        if (rst) begin
            shown <= '0;
        end else if (pop) begin
            shown <= mem[rd_ptr];  // Only at the frame boundary.
        end
    end

    // A write into a full queue means the host spent a credit it did not hold.
    a_no_overrun: assert property (
        @(posedge clock) disable iff (rst) wr.valid |-> (count != CNT_W'(DEPTH))
    );

    a_count_range: assert property (
        @(posedge clock) disable iff (rst) count <= CNT_W'(DEPTH)
    );

endmodule

// ==== logic/seg_display_top.sv ====
`timescale 1ns/1ns

module seg_display_top
    import seg_pkg::*;
#(
    parameter int TICK_DIV = 100000,  // Clocks per digit step.
    parameter int DEPTH    = 2        // Queue entries, equal to host credits.
) (
    input  logic     clock,
    input  logic     rst,
    input  disp_wr_t wr,
    output logic     credit,
    output seg_t     ca,
    output anode_t   an
);

    logic        tick;
    logic        frame_end;
    disp_value_t shown;
    nibble_t     nibble;
    seg_t        glyph;

    scan_tick_gen #(
        .TICK_DIV (TICK_DIV)
    ) u_scan_tick_gen (
        .clock (clock),
        .rst   (rst),
        .tick  (tick)
    );

    digit_scanner u_digit_scanner (
        .clock     (clock),
        .rst       (rst),
        .tick      (tick),
        .shown     (shown),
        .glyph     (glyph),
        .nibble    (nibble),
        .frame_end (frame_end),
        .ca        (ca),
        .an        (an)
    );

    hex_glyph_rom u_hex_glyph_rom (
        .nibble (nibble),
        .glyph  (glyph)
    );

    // Host values wait here until the scan wraps.
    frame_buffer #(
        .DEPTH (DEPTH)
    ) u_frame_buffer (
        .clock     (clock),
        .rst       (rst),
        .wr        (wr),
        .frame_end (frame_end),
        .shown     (shown),
        .credit    (credit)
    );

endmodule

// ==== tb/seg_display_tb.sv ====
`timescale 1ns/1ns

module seg_display_tb
    import seg_pkg::*;
();

    localparam int TICK_DIV   = 4;
    localparam int DEPTH      = 2;
    localparam int CLK_HALF   = 4;
    localparam int WAIT_LIMIT = 200;  // About six frames.

    logic     clock;
    logic     rst;
    disp_wr_t wr;
    logic     credit;
    seg_t     ca;
    anode_t   an;

    int     writes_done;
    int     pulses_seen;
    int     pulses_taken;
    anode_t prev_an;

    seg_display_top #(
        .TICK_DIV (TICK_DIV),
        .DEPTH    (DEPTH)
    ) u_seg_display_top (
        .clock  (clock),
        .rst    (rst),
        .wr     (wr),
        .credit (credit),
        .ca     (ca),
        .an     (an)
    );

    initial begin
        clock = 1'b0;
        forever #CLK_HALF clock = ~clock;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Failure reporting.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at %0t.", $time);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s at %0t.", what, $time);
        abort_run();
    endtask

    // Anode order and credit returns sampled mid-cycle.
    always @(negedge clock) begin
        if (rst) begin
            prev_an = 8'hFE;
        end else begin
            if (an !== prev_an) begin
                check_value("an", 32'(an), 32'({prev_an[6:0], prev_an[7]}));
            end
            prev_an = an;
            if (credit === 1'b1) begin
                pulses_seen = pulses_seen + 1;
                if (pulses_seen > writes_done) begin
                    report_failure("Credit returned with no value queued");
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus commands.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Reads the next command letter past blanks and comment lines.
    task automatic read_command(input int fd, output logic [7:0] cmd, output bit at_end);
        int c;
        at_end = 1'b0;
        cmd    = 8'h00;
        c      = $fgetc(fd);
        while (c != -1 && (c == 32 || c == 9 || c == 10 || c == 13 || c == 35)) begin
            if (c == 35) begin
                while (c != -1 && c != 10) begin
                    c = $fgetc(fd);
                end
            end
            c = $fgetc(fd);
        end
        if (c == -1) begin
            at_end = 1'b1;
        end else begin
            cmd = c[7:0];
        end
    endtask

    task automatic write_value(input disp_value_t value);
        int idle;
        idle = int'($urandom_range(3, 0));
        repeat (idle) @(posedge clock);
        @(posedge clock);
        #1;
        if (DEPTH - writes_done + pulses_seen <= 0) begin
            report_failure("Write attempted while the host holds no credit");
        end else begin
            wr.valid    = 1'b1;
            wr.value    = value;
            writes_done = writes_done + 1;
            @(posedge clock);
            #1;
            wr.valid = 1'b0;
        end
    endtask

    task automatic wait_credit();
        int cycles;
        cycles = 0;
        while (pulses_seen <= pulses_taken) begin
            if (cycles >= WAIT_LIMIT) begin
                report_failure("Timed out waiting for a credit pulse");
            end else begin
                @(posedge clock);
                cycles = cycles + 1;
            end
        end
        pulses_taken = pulses_taken + 1;
    endtask

    task automatic expect_digit(input int digit, input seg_t glyph);
        anode_t want;
        int     cycles;
        int     i;
        for (i = 0; i < DIGITS; i++) begin
            want[i] = (i != digit);  // Only the selected digit is low.
        end
        cycles = 0;
        @(negedge clock);
        while (an !== want) begin
            if (cycles >= WAIT_LIMIT) begin
                report_failure($sformatf("Timed out waiting for the anode of digit %0d", digit));
            end else begin
                @(negedge clock);
                cycles = cycles + 1;
            end
        end
        check_value($sformatf("ca (digit %0d)", digit), 32'(ca), 32'(glyph));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int          fd;
        int          code;
        int          digit;
        logic [7:0]  cmd;
        logic [31:0] arg;
        bit          at_end;

        rst = 1'b1;
        wr  = '0;
        void'($urandom(7));
        fd  = $fopen("tb/seg_display_stimulus.txt", "r");
        if (fd == 0) begin
            report_failure("Cannot open the stimulus file");
        end
        repeat (2) @(posedge clock);
        #1;
        rst = 1'b0;

        at_end = 1'b0;
        while (!at_end) begin
            read_command(fd, cmd, at_end);
            if (!at_end) begin
                case (cmd)
                    "W": begin
                        code = $fscanf(fd, "%h", arg);
                        if (code != 1) begin
                            report_failure("Missing value after a write command");
                        end else begin
                            write_value(arg);
                        end
                    end
                    "C": begin
                        wait_credit();
                    end
                    "E": begin
                        code = $fscanf(fd, "%d %h", digit, arg);
                        if (code != 2 || digit < 0 || digit > 7) begin
                            report_failure("Malformed digit check in the stimulus file");
                        end else begin
                            expect_digit(digit, arg[7:0]);
                        end
                    end
                    default: begin
                        report_failure($sformatf("Unknown command '%c' in the stimulus file", cmd));
                    end
                endcase
            end
        end
        $fclose(fd);

        @(posedge clock);
        check_value("host credits", 32'(DEPTH - writes_done + pulses_seen), 32'(DEPTH));
        check_value("credit pulses", 32'(pulses_seen), 32'(writes_done));
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== tb/seg_display_stimulus.txt ====
# W <hex value> | C (wait for one credit) | E <digit 0-7> <hex glyph>
# Digit 0 is the rightmost; glyphs are active-low cathodes, bit 7 the decimal point.
E 0 C0
E 1 C0
E 2 C0
E 3 C0
E 4 C0
E 5 C0
E 6 C0
E 7 C0
W 89ABCDEF
C
E 0 8E
E 1 86
E 2 A1
E 3 C6
E 4 83
E 5 88
E 6 90
E 7 80
E 3 C6
W 01234567
W FEDCBA98
C
E 0 F8
E 1 82
E 2 92
E 3 99
W 2468ACE0
E 4 B0
E 5 A4
E 6 F9
E 7 C0
C
E 0 80
E 1 90
E 2 88
E 3 83
E 4 C6
E 5 A1
E 6 86
E 7 8E
C
E 0 C0
E 1 86
E 2 C6
E 3 88
E 4 80
E 5 82
E 6 99
E 7 A4

// ==== sources.f ====
logic/seg_pkg.sv
logic/scan_tick_gen.sv
logic/hex_glyph_rom.sv
logic/digit_scanner.sv
logic/frame_buffer.sv
logic/seg_display_top.sv
tb/seg_display_tb.sv

// ==== Makefile ====
TOP := seg_display_tb

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log || (echo "No pass message in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
